/* icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// byte offset bits within a line
// 4 gives a 16 byte line of 4 words
`define ICACHE_OFFSET_W 4

// set index bits
// 2 gives 4 sets
`define ICACHE_INDEX_W 2

// top address nibble at and above which fetches are cached
// covers flash and sdram, the fast sram below it is left alone
`define ICACHE_CACHEABLE_BASE 4'h3

`endif

/* icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

  localparam int tag_w      = 32 - `ICACHE_OFFSET_W - `ICACHE_INDEX_W;
  localparam int word_off_w = `ICACHE_OFFSET_W - 2;   // word select within line
  localparam int line_words = 1 << word_off_w;
  localparam int set_n      = 1 << `ICACHE_INDEX_W;

  typedef struct packed {
    logic [31:0] addr;   // word aligned
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] data;
  } fetch_resp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;    // beats minus one
    logic        wrap;   // line burst
  } mem_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } mem_r_t;

  typedef enum logic [2:0] {
    st_idle,
    st_hit_resp,   // also the tag compare cycle
    st_ar,
    st_refill,
    st_bypass_ar,
    st_bypass_r,
    st_miss_resp
  } ctrl_state_t;

endpackage

/* icache_tag_array.sv */
`include "icache_defines.svh"

module icache_tag_array (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic [`ICACHE_INDEX_W-1:0]   index,
  input  logic [icache_pkg::tag_w-1:0] tag,
  input  logic                         fill_en,
  input  logic                         flush_en,
  output logic                         hit
);
  import icache_pkg::*;

  logic [set_n-1:0] valid_q;
  logic [tag_w-1:0] tag_q [set_n];

  // valid bits are control state, cleared by reset and by flush
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
    end else if (flush_en) begin
      valid_q <= '0;               // fence
    end else if (fill_en) begin
      valid_q[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[index] <= tag;         // written on the last beat
    end
  end

  // combinational compare against the registered address
  assign hit = valid_q[index] && (tag_q[index] == tag);

endmodule

/* icache_data_array.sv */
`include "icache_defines.svh"

module icache_data_array (
  input  logic                              clk,
  input  logic [`ICACHE_INDEX_W-1:0]        index,
  input  logic [icache_pkg::word_off_w-1:0] wr_off,
  input  logic                              wr_en,
  input  logic [31:0]                       wr_data,
  input  logic [icache_pkg::word_off_w-1:0] rd_off,
  output logic [31:0]                       rd_data
);
  import icache_pkg::*;

  logic [31:0] line_q [set_n][line_words];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      line_q[index][wr_off] <= wr_data;   // one word per beat
    end
  end

  assign rd_data = line_q[index][rd_off];

endmodule

/* icache_refill_counter.sv */
module icache_refill_counter (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              start,
  input  logic [icache_pkg::word_off_w-1:0] start_off,
  input  logic                              step,
  output logic [icache_pkg::word_off_w-1:0] off,
  output logic                              done
);
  import icache_pkg::*;

  logic [word_off_w-1:0] off_q;
  logic [word_off_w:0]   cnt_q;    // one extra bit to reach line_words

  always_ff @(posedge clk) begin
    if (!rstn) begin
      off_q <= '0;
      cnt_q <= '0;
    end else if (start) begin
      off_q <= start_off;          // critical word first
      cnt_q <= '0;
    end else if (step) begin
      off_q <= off_q + 1'b1;       // wraps modulo line_words
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign off  = off_q;
  assign done = (cnt_q == (word_off_w + 1)'(line_words));

endmodule

/* icache_ctrl.sv */
module icache_ctrl (
  input  logic               clk,
  input  logic               rstn,
  input  logic               req_valid,
  input  logic               resp_ready,
  input  logic               mem_ar_ready,
  input  logic               mem_r_valid,
  input  icache_pkg::mem_r_t mem_r,
  input  logic               flush,
  input  logic               hit,
  input  logic               cacheable,
  output logic               req_ready,
  output logic               resp_valid,
  output logic               mem_ar_valid,
  output logic               mem_r_ready,
  output logic               req_take,
  output logic               fill_en,
  output logic               line_wr,
  output logic               flush_en,
  output logic               cnt_start,
  output logic               cnt_step,
  output logic               bypass_take,
  output logic               resp_from_line
);
  import icache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        r_beat;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign r_beat = mem_r_valid && mem_r_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (req_take) begin
          state_nxt = st_hit_resp;
        end
      end
      st_hit_resp: begin
        if (!cacheable) begin
          state_nxt = st_bypass_ar;
        end else if (!hit) begin
          state_nxt = st_ar;
        end else if (resp_ready) begin
          state_nxt = st_idle;
        end
      end
      st_ar: begin
        if (mem_ar_ready) begin
          state_nxt = st_refill;
        end
      end
      st_refill: begin
        if (r_beat && mem_r.last) begin
          state_nxt = st_miss_resp;
        end
      end
      st_bypass_ar: begin
        if (mem_ar_ready) begin
          state_nxt = st_bypass_r;
        end
      end
      st_bypass_r: begin
        if (r_beat) begin
          state_nxt = st_miss_resp;
        end
      end
      st_miss_resp: begin
        if (resp_ready) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  // fetch side
  assign req_ready = (state == st_idle) && !flush;   // no accept during flush
  assign req_take  = req_valid && req_ready;
  assign flush_en  = (state == st_idle) && flush;

  assign resp_valid = ((state == st_hit_resp) && cacheable && hit) ||
                      (state == st_miss_resp);
  assign resp_from_line = (state == st_hit_resp) ||
                          ((state == st_miss_resp) && cacheable);

  // bus side
  assign mem_ar_valid = (state == st_ar) || (state == st_bypass_ar);
  assign mem_r_ready  = (state == st_refill) || (state == st_bypass_r);

  assign cnt_start   = (state == st_ar) && mem_ar_ready;
  assign cnt_step    = (state == st_refill) && r_beat;
  assign line_wr     = cnt_step;
  assign fill_en     = cnt_step && mem_r.last;            // tag goes in with the last beat
  assign bypass_take = (state == st_bypass_r) && r_beat;

endmodule

/* icache_top.sv */
`include "icache_defines.svh"

module icache_top (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    req_valid,
  input  icache_pkg::fetch_req_t  req,
  output logic                    req_ready,
  output logic                    resp_valid,
  output icache_pkg::fetch_resp_t resp,
  input  logic                    resp_ready,
  output logic                    mem_ar_valid,
  output icache_pkg::mem_ar_t     mem_ar,
  input  logic                    mem_ar_ready,
  input  logic                    mem_r_valid,
  input  icache_pkg::mem_r_t      mem_r,
  output logic                    mem_r_ready,
  input  logic                    flush
);
  import icache_pkg::*;

  fetch_req_t                 req_q;
  logic [31:0]                bypass_q;
  logic [tag_w-1:0]           tag;
  logic [`ICACHE_INDEX_W-1:0] index;
  logic [word_off_w-1:0]      word_off;
  logic [word_off_w-1:0]      cnt_off;
  logic [31:0]                line_word;
  logic cacheable, hit;
  logic req_take, fill_en, line_wr, flush_en, cnt_start, cnt_step;
  logic bypass_take, resp_from_line, cnt_done;

  always_ff @(posedge clk) begin
    if (req_take) begin
      req_q <= req;
    end
    if (bypass_take) begin
      bypass_q <= mem_r.data;
    end
  end

  assign tag       = req_q.addr[31 -: tag_w];
  assign index     = req_q.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign word_off  = req_q.addr[2 +: word_off_w];
  assign cacheable = req_q.addr[31:28] >= `ICACHE_CACHEABLE_BASE;

  // requested word first, the burst wraps around the line
  assign mem_ar.addr = req_q.addr;
  assign mem_ar.len  = cacheable ? 8'(line_words - 1) : 8'd0;
  assign mem_ar.wrap = cacheable;

  assign resp.data = resp_from_line ? line_word : bypass_q;

  icache_ctrl ctrl_i (
    .clk, .rstn, .req_valid, .resp_ready, .mem_ar_ready, .mem_r_valid, .mem_r,
    .flush, .hit, .cacheable, .req_ready, .resp_valid, .mem_ar_valid, .mem_r_ready,
    .req_take, .fill_en, .line_wr, .flush_en, .cnt_start, .cnt_step,
    .bypass_take, .resp_from_line
  );

  icache_refill_counter cnt_i (
    .clk, .rstn, .start(cnt_start), .start_off(word_off), .step(cnt_step),
    .off(cnt_off), .done(cnt_done)
  );

  icache_tag_array tag_i (
    .clk, .rstn, .index, .tag, .fill_en, .flush_en, .hit
  );

  // extra beats past a full line are dropped
  icache_data_array data_i (
    .clk, .index, .wr_off(cnt_off), .wr_en(line_wr && !cnt_done),
    .wr_data(mem_r.data), .rd_off(word_off), .rd_data(line_word)
  );

endmodule

/* icache_checker.sv */
module icache_checker (
  input logic                    clk,
  input logic                    rstn,
  input logic                    resp_valid,
  input logic                    resp_ready,
  input icache_pkg::fetch_resp_t resp,
  input logic                    mem_ar_valid,
  input logic                    mem_ar_ready,
  input icache_pkg::mem_ar_t     mem_ar,
  input logic                    mem_r_ready
);
  int fail_cnt = 0;   // polled by tb_icache

  resp_hold_a : assert property (
    @(posedge clk) disable iff (!rstn)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  ) else begin
    $error("resp_valid dropped or resp changed before the transfer");
    fail_cnt++;
  end

  ar_hold_a : assert property (
    @(posedge clk) disable iff (!rstn)
    mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar)
  ) else begin
    $error("mem_ar_valid dropped or mem_ar changed before the transfer");
    fail_cnt++;
  end

  // beats are only taken once a bus read went out
  r_ready_a : assert property (
    @(posedge clk) disable iff (!rstn)
    $rose(mem_r_ready) |-> $past(mem_ar_valid && mem_ar_ready)
  ) else begin
    $error("mem_r_ready high outside a refill or bypass read");
    fail_cnt++;
  end

  reset_quiet_a : assert property (
    @(posedge clk) (!rstn ##1 !rstn) |-> !resp_valid && !mem_ar_valid && !mem_r_ready
  ) else begin
    $error("outputs not low during reset");
    fail_cnt++;
  end

endmodule

bind icache_top icache_checker chk_i (
  .clk, .rstn, .resp_valid, .resp_ready, .resp,
  .mem_ar_valid, .mem_ar_ready, .mem_ar, .mem_r_ready
);

/* tb_icache.sv */
module tb_icache;
  import icache_pkg::*;

  localparam int off_w = word_off_w + 2;
  localparam int idx_w = $clog2(set_n);
  // 32 fetches at most, each within 40 cycles of ar gap, beat gaps and held response
  localparam int timeout_cycles = 32 * 40 + 100;

  logic        clk, rstn, flush;
  logic        req_valid, req_ready, resp_valid, resp_ready;
  logic        mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  fetch_req_t  req;
  fetch_resp_t resp;
  mem_ar_t     mem_ar;
  mem_r_t      mem_r;

  logic [31:0]      lfsr = 32'h8c01a573;
  logic [set_n-1:0] model_valid;
  logic [tag_w-1:0] model_tag [set_n];
  int               ar_count, exp_ar_count, cycles;

  icache_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    stop_run("timeout: the cache stopped answering before all tests were done");
  end

  // counts the ar transfers that take place on the coming rising edge
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (mem_ar_valid && mem_ar_ready) ar_count++;
      if (dut_i.chk_i.fail_cnt != 0) stop_run("the bound checker reported an assertion failure");
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic compare_resp(input fetch_resp_t got, input fetch_resp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t: resp data %h, expected %h", $time, got.data, exp.data));
    end
  endtask

  task automatic compare_ar(input mem_ar_t got, input mem_ar_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t: mem_ar %h len %0d wrap %b, expected %h len %0d wrap %b",
                         $time, got.addr, got.len, got.wrap, exp.addr, exp.len, exp.wrap));
    end
  endtask

  task automatic check_count(input string what);
    if (ar_count != exp_ar_count) begin
      stop_run($sformatf("ERROR at %0t: %s saw %0d bus reads, expected %0d",
                         $time, what, ar_count, exp_ar_count));
    end
  endtask

  // bus slave, data is the inverse of the word address
  task automatic serve_bus(input mem_ar_t exp_ar);
    logic [31:0] base;
    int          off;
    while (!mem_ar_valid) begin
      if (resp_valid) stop_run("response came without a bus read on a predicted miss");
      @(negedge clk);
      #1;
    end
    compare_ar(mem_ar, exp_ar);
    repeat (1 + int'(rand_bits(2))) @(negedge clk);
    mem_ar_ready = 1'b1;
    @(negedge clk);
    mem_ar_ready = 1'b0;
    base = {exp_ar.addr[31:off_w], {off_w{1'b0}}};
    for (int i = 0; i <= int'(exp_ar.len); i++) begin
      repeat (rand_bits(2)) @(negedge clk);
      off         = (int'(exp_ar.addr[off_w-1:2]) + i) % line_words;   // wrapping order
      mem_r.data  = exp_ar.wrap ? ~(base + 32'(off * 4)) : ~exp_ar.addr;
      mem_r.last  = (i == int'(exp_ar.len));
      mem_r_valid = 1'b1;
      #1;
      while (!mem_r_ready) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
      mem_r_valid = 1'b0;
    end
    #1;
  endtask

  task automatic fetch(input logic [31:0] addr, input int hold);
    int               idx;
    logic [tag_w-1:0] tg;
    logic             cacheable, exp_hit;
    mem_ar_t          exp_ar;
    fetch_resp_t      exp_resp;
    idx           = int'(addr[off_w +: idx_w]);
    tg            = addr[31 -: tag_w];
    cacheable     = addr[31:28] >= 4'h3;
    exp_hit       = cacheable && model_valid[idx] && (model_tag[idx] == tg);
    exp_resp.data = ~addr;
    exp_ar.addr   = addr;
    exp_ar.len    = cacheable ? 8'(line_words - 1) : 8'd0;
    exp_ar.wrap   = cacheable;
    @(negedge clk);
    req_valid = 1'b1;
    req.addr  = addr;
    #1;
    while (!req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);   // taken on the edge just passed
    req_valid = 1'b0;
    #1;
    if (exp_hit) begin
      if (!resp_valid || mem_ar_valid) stop_run("hit was not answered in the cycle after accept");
    end else begin
      exp_ar_count++;
      serve_bus(exp_ar);
      if (cacheable) begin
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tg;
      end
    end
    while (!resp_valid) begin
      @(negedge clk);
      #1;
    end
    repeat (hold) begin
      compare_resp(resp, exp_resp);
      if (req_ready) stop_run("a new request could be taken while a response was pending");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    resp_ready = 1'b1;
    #1;
    if (!resp_valid) stop_run("response was withdrawn before it was taken");
    compare_resp(resp, exp_resp);
    @(negedge clk);
    resp_ready = 1'b0;
  endtask

  task automatic test_cold_miss();
    fetch(32'h3000_0008, 0);
    check_count("cold miss");
  endtask

  task automatic test_hit();
    for (int w = 0; w < line_words; w++) begin
      fetch(32'h3000_0000 + 32'(w * 4), 0);
    end
    check_count("line hits");
  endtask

  task automatic test_conflict();
    repeat (2) begin
      fetch(32'h4000_0024, 0);
      fetch(32'h5000_0024, 0);   // same set, other tag
    end
    check_count("conflict");
  endtask

  task automatic test_bypass();
    repeat (2) fetch(32'h1000_0104, 0);
    check_count("bypass");
  endtask

  task automatic test_flush();
    fetch(32'h6000_0010, 0);
    fetch(32'h6000_0014, 0);
    @(negedge clk);
    flush = 1'b1;
    #1;
    if (req_ready) stop_run("a request could be taken in the flush cycle");
    @(negedge clk);
    flush       = 1'b0;
    model_valid = '0;
    fetch(32'h6000_0014, 0);   // misses again
    check_count("flush");
  endtask

  task automatic test_backpressure();
    logic [3:0]  top;
    logic [3:0]  low;
    repeat (8) begin
      top = 4'h2 + 4'(rand_bits(1));   // mix of bypass and cached
      low = 4'(rand_bits(4));
      fetch({top, 22'd0, low, 2'b00}, 1 + int'(rand_bits(3)));
    end
    check_count("back-pressure");
  endtask

  initial begin
    rstn         = 1'b0;
    flush        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    resp_ready   = 1'b0;
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r        = '0;
    model_valid  = '0;
    ar_count     = 0;
    exp_ar_count = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    test_cold_miss();
    test_hit();
    test_conflict();
    test_bypass();
    test_flush();
    test_backpressure();
    if (dut_i.chk_i.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run("the bound checker reported assertion failures");
    end
  end

endmodule

/* vlog.f */
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill_counter.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

/* Bender.yml */
package:
  name: icache

export_include_dirs:
  - .

sources:
  - files:
      - icache_pkg.sv
      - icache_tag_array.sv
      - icache_data_array.sv
      - icache_refill_counter.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    files:
      - icache_checker.sv
      - tb_icache.sv
